//--- design/gb_io_macros.svh
// high i/o page register addresses, reset values and fixed read patterns
`ifndef GB_IO_MACROS_SVH
`define GB_IO_MACROS_SVH

// ------------------------------------------------
// register addresses in the ff page
// ------------------------------------------------
`define GB_ADDR_P1    16'hFF00  // joypad select and lines
`define GB_ADDR_IF    16'hFF0F  // interrupt flags
`define GB_ADDR_KEY1  16'hFF4D  // speed switch, cgb only
`define GB_ADDR_BOOT  16'hFF50  // boot rom disable
`define GB_ADDR_RP    16'hFF56  // infrared port
`define GB_ADDR_SVBK  16'hFF70  // wram bank select
`define GB_ADDR_FF72  16'hFF72
`define GB_ADDR_FF73  16'hFF73
`define GB_ADDR_FF74  16'hFF74  // needs a cgb game
`define GB_ADDR_FF75  16'hFF75  // only bits 6..4 stored
`define GB_ADDR_IE    16'hFFFF  // interrupt enable

// ------------------------------------------------
// fixed read patterns
// ------------------------------------------------
`define GB_FAST_BOOT_FLAG 8'h42  // boot rom looks for this in ff50
`define GB_OPEN_BUS       8'hFF  // nothing drives the data lines
`define GB_RP_READ        8'h02  // ir port with no light seen

// reset values
`define GB_SVBK_RESET     3'd1   // bank 0 is never selected here

// boot rom unmap pattern in cgb mode
`define GB_BOOT_GBC_OFF   8'h11

`endif

//--- design/gb_bus_pkg.sv
// cpu bus widths and register select encoding for the system glue
package gb_bus_pkg;

	typedef logic [7:0]  byte_t;       // cpu data byte
	typedef logic [15:0] addr_t;       // cpu address
	typedef logic [14:0] wram_addr_t;  // 32k work ram
	typedef logic [2:0]  wram_bank_t;  // svbk bank number

	// ------------------------------------------------
	// select bit positions
	// ------------------------------------------------
	localparam int SEL_P1   = 0;
	localparam int SEL_IF   = 1;
	localparam int SEL_KEY1 = 2;
	localparam int SEL_BOOT = 3;   // ff50 as a plain write target
	localparam int SEL_FAST = 4;   // ff50 while the fast boot flag is shown
	localparam int SEL_RP   = 5;
	localparam int SEL_SVBK = 6;
	localparam int SEL_FF72 = 7;
	localparam int SEL_FF73 = 8;
	localparam int SEL_FF74 = 9;
	localparam int SEL_FF75 = 10;
	localparam int SEL_IE   = 11;
	localparam int SEL_MEM  = 12;  // rom cram vram wram zero page
	localparam int SEL_OPEN = 13;  // unmapped, always the top bit

	typedef logic [SEL_OPEN:0] io_sel_t;  // exactly one bit set

endpackage

//--- design/gb_irq_pkg.sv
// interrupt flag, vector and joypad line types
package gb_irq_pkg;

	// flag order is also the priority order
	// bit 0 vblank, 1 lcd, 2 timer, 3 serial, 4 joypad
	typedef logic [4:0] irq_flags_t;

	typedef logic [7:0] irq_vec_t;    // restart address fed to the cpu
	typedef logic [3:0] joy_lines_t;  // p10..p13, active low

	// ------------------------------------------------
	// vector table
	// ------------------------------------------------
	localparam irq_vec_t IRQ_VEC_BASE = 8'h40;  // vblank
	localparam int       IRQ_VEC_STEP = 8;      // 40 48 50 58 60

endpackage

//--- design/gb_cpu_bus_if.sv
// cpu write side and cpu clock enable shared by the glue blocks
`timescale 1ns/1ps

interface gb_cpu_bus_if;
	import gb_bus_pkg::*;

	addr_t addr;    // cpu address
	byte_t wdata;   // cpu write data
	logic  wr;      // level write strobe
	logic  cpu_ce;  // follows the speed bit

	// system register block owns the clock enable
	modport regs (
		input  addr,
		input  wdata,
		input  wr,
		output cpu_ce
	);

	// decoder and irq controller only listen
	modport sink (
		input addr,
		input wdata,
		input wr,
		input cpu_ce
	);

endinterface

//--- design/gb_addr_decode.sv
// high page address decoder and cpu read data multiplexer
`timescale 1ns/1ps
`include "gb_io_macros.svh"

module gb_addr_decode (
	gb_cpu_bus_if.sink           bus,
	input  logic                 is_gbc,
	input  logic                 gbc_game,
	input  logic                 fast_boot,
	input  logic                 boot_rom_on,
	input  logic                 irq_ack,
	input  gb_irq_pkg::irq_vec_t irq_vec,
	input  gb_bus_pkg::byte_t    sys_rdata,
	input  gb_bus_pkg::byte_t    irq_rdata,
	input  gb_bus_pkg::byte_t    mem_rdata,
	output gb_bus_pkg::io_sel_t  io_sel,
	output gb_bus_pkg::byte_t    cpu_rdata
);
	import gb_bus_pkg::*;

	wire [SEL_OPEN-1:0] hit;  // all mapped targets
	addr_t a;
	logic  gbc_mode;  // cgb hardware running a cgb game
	logic  at_boot;
	logic  fast_on;
	logic  mem_hit;
	logic  sys_hit;
	logic  irq_hit;

	assign a        = bus.addr;
	assign gbc_mode = is_gbc && gbc_game;
	assign at_boot  = (a == `GB_ADDR_BOOT);
	assign fast_on  = fast_boot && boot_rom_on;  // flag gone once rom unmaps

	// ------------------------------------------------
	// memory regions, all read through mem_rdata
	// ------------------------------------------------
	assign mem_hit = !a[15]                                // rom 0000-7fff
		|| (a[15:13] == 3'b100)                            // vram
		|| (a[15:13] == 3'b101)                            // cart ram
		|| ((a[15:14] == 2'b11) && !(&a[13:9]))            // wram plus echo
		|| ((a[15:7] == 9'h1ff) && (a != `GB_ADDR_IE));    // zero page

	// ------------------------------------------------
	// register selects
	// ------------------------------------------------
	assign hit[SEL_P1]   = (a == `GB_ADDR_P1);
	assign hit[SEL_IF]   = (a == `GB_ADDR_IF);
	assign hit[SEL_KEY1] = gbc_mode && (a == `GB_ADDR_KEY1);
	assign hit[SEL_BOOT] = at_boot && !fast_on;
	assign hit[SEL_FAST] = at_boot && fast_on;
	assign hit[SEL_RP]   = gbc_mode && (a == `GB_ADDR_RP);
	assign hit[SEL_SVBK] = is_gbc && (gbc_game || boot_rom_on)  // boot rom banks too
		&& (a == `GB_ADDR_SVBK);
	assign hit[SEL_FF72] = is_gbc && (a == `GB_ADDR_FF72);
	assign hit[SEL_FF73] = is_gbc && (a == `GB_ADDR_FF73);
	assign hit[SEL_FF74] = gbc_mode && (a == `GB_ADDR_FF74);
	assign hit[SEL_FF75] = is_gbc && (a == `GB_ADDR_FF75);
	assign hit[SEL_IE]   = (a == `GB_ADDR_IE);
	assign hit[SEL_MEM]  = mem_hit;

	assign io_sel = {~|hit, hit};  // open bus when nothing else matched

	assign sys_hit = hit[SEL_P1] || hit[SEL_KEY1] || hit[SEL_SVBK]
		|| hit[SEL_FF72] || hit[SEL_FF73] || hit[SEL_FF74] || hit[SEL_FF75];
	assign irq_hit = hit[SEL_IF] || hit[SEL_IE];

	// read mux, acknowledge cycle first
	assign cpu_rdata =
		irq_ack        ? irq_vec            :  // restart vector
		hit[SEL_FAST]  ? `GB_FAST_BOOT_FLAG :
		hit[SEL_RP]    ? `GB_RP_READ        :
		sys_hit        ? sys_rdata          :
		irq_hit        ? irq_rdata          :
		mem_hit        ? mem_rdata          :
		`GB_OPEN_BUS;                          // ff50 lands here too

endmodule

//--- design/gb_sys_regs.sv
// system configuration registers and the banked wram address they steer
`timescale 1ns/1ps
`include "gb_io_macros.svh"

module gb_sys_regs (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	gb_cpu_bus_if.regs             bus,
	input  gb_bus_pkg::io_sel_t    io_sel,
	input  logic                   is_gbc,
	input  logic                   ce,
	input  logic                   ce_2x,
	input  logic                   cpu_stop,
	input  gb_irq_pkg::joy_lines_t joy_din,
	output gb_bus_pkg::byte_t      sys_rdata,
	output logic [1:0]             joy_p54,
	output logic                   speed,
	output logic                   boot_rom_on,
	output gb_bus_pkg::wram_addr_t wram_addr
);
	import gb_bus_pkg::*;

	logic       wr_en;     // write strobe on a cpu clock enable
	logic       prepare;   // key1 bit 0, armed switch
	logic       boot_off;  // write data unmaps the boot rom
	wram_bank_t svbk;
	wram_bank_t bank;
	byte_t      ff72;
	byte_t      ff73;
	byte_t      ff74;
	logic [2:0] ff75;

	// ------------------------------------------------
	// cpu clock enable
	// ------------------------------------------------
	assign bus.cpu_ce = speed ? ce_2x : ce;  // double speed
	assign wr_en      = bus.wr && bus.cpu_ce;

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			joy_p54 <= 2'b00;
		else if (wr_en && io_sel[SEL_P1])
			joy_p54 <= bus.wdata[5:4];  // only the select pair is writable
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			svbk <= `GB_SVBK_RESET;
		else if (wr_en && io_sel[SEL_SVBK])
			svbk <= (bus.wdata[2:0] == 3'd0) ? 3'd1 : bus.wdata[2:0];  // 0 maps to 1
	end

	// speed switch, armed through key1 and fired by stop
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			speed   <= 1'b0;
			prepare <= 1'b0;
		end else begin
			if (wr_en && io_sel[SEL_KEY1])
				prepare <= bus.wdata[0];
			if (bus.cpu_ce && cpu_stop && prepare && is_gbc) begin
				speed   <= ~speed;
				prepare <= 1'b0;  // one shot
			end
		end
	end

	// ------------------------------------------------
	// boot rom mapping
	// ------------------------------------------------
	assign boot_off = is_gbc ? (bus.wdata == `GB_BOOT_GBC_OFF) : bus.wdata[0];

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			boot_rom_on <= 1'b1;
		else if (wr_en && (io_sel[SEL_BOOT] || io_sel[SEL_FAST]) && boot_off)
			boot_rom_on <= 1'b0;  // no way back until reset
	end

	// spare cgb registers
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ff72 <= '0;
			ff73 <= '0;
			ff74 <= '0;
			ff75 <= '0;
		end else if (wr_en) begin
			if (io_sel[SEL_FF72])
				ff72 <= bus.wdata;
			if (io_sel[SEL_FF73])
				ff73 <= bus.wdata;
			if (io_sel[SEL_FF74])
				ff74 <= bus.wdata;
			if (io_sel[SEL_FF75])
				ff75 <= bus.wdata[6:4];
		end
	end

	// ------------------------------------------------
	// readback and wram banking
	// ------------------------------------------------
	assign sys_rdata =
		io_sel[SEL_P1]   ? {2'b11, joy_p54, joy_din} :
		io_sel[SEL_SVBK] ? {5'h1f, svbk}             :
		io_sel[SEL_KEY1] ? {speed, 6'h3f, prepare}   :
		io_sel[SEL_FF72] ? ff72                      :
		io_sel[SEL_FF73] ? ff73                      :
		io_sel[SEL_FF74] ? ff74                      :
		io_sel[SEL_FF75] ? {1'b1, ff75, 4'hf}        :
		`GB_OPEN_BUS;

	assign bank      = bus.addr[12] ? svbk : 3'd0;  // c000 half is fixed bank 0
	assign wram_addr = {bank, bus.addr[11:0]};

endmodule

//--- design/gb_irq_ctrl.sv
// interrupt controller with enable and flag registers, edge capture and vectoring
`timescale 1ns/1ps

module gb_irq_ctrl (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	gb_cpu_bus_if.sink             bus,
	input  gb_bus_pkg::io_sel_t    io_sel,
	input  logic                   ev_vblank,
	input  logic                   ev_lcd,
	input  logic                   ev_timer,
	input  logic                   ev_serial,
	input  logic                   irq_ack,
	input  gb_irq_pkg::joy_lines_t joy_din,
	output gb_bus_pkg::byte_t      irq_rdata,
	output gb_irq_pkg::irq_vec_t   irq_vec,
	output logic                   irq_n
);
	import gb_bus_pkg::*;
	import gb_irq_pkg::*;

	byte_t      ie_r;      // full byte kept, upper bits read back
	irq_flags_t if_r;
	irq_flags_t if_next;
	irq_flags_t pending;   // enabled and flagged
	irq_flags_t ack_clr;   // lowest pending bit only
	logic [3:0] ev_now;
	logic [3:0] ev_prev;
	logic       ack_prev;
	logic       ack_end;
	joy_lines_t joy_s1;    // first sync stage
	joy_lines_t joy_s2;
	logic       joy_fall;

	assign ev_now   = {ev_serial, ev_timer, ev_lcd, ev_vblank};
	assign pending  = ie_r[4:0] & if_r;
	assign irq_n    = ~|pending;
	assign joy_fall = |(~joy_s1 & joy_s2);   // any line went low
	assign ack_end  = ack_prev && !irq_ack;
	assign ack_clr  = pending & (~pending + 5'd1);

	// ------------------------------------------------
	// vector, lowest pending index wins
	// ------------------------------------------------
	always_comb begin
		irq_vec = 8'h00;
		for (int i = 4; i >= 0; i--) begin
			if (pending[i])
				irq_vec = IRQ_VEC_BASE + irq_vec_t'(i * IRQ_VEC_STEP);
		end
	end

	// rising events and joypad fall set, acknowledge end clears
	always_comb begin
		if_next = if_r | {joy_fall, ev_now & ~ev_prev};
		if (ack_end)
			if_next = if_next & ~ack_clr;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_r     <= '0;
			if_r     <= '0;
			ev_prev  <= '0;
			ack_prev <= 1'b0;
			joy_s1   <= '1;  // lines idle high
			joy_s2   <= '1;
		end else if (bus.cpu_ce) begin
			ev_prev  <= ev_now;
			ack_prev <= irq_ack;
			joy_s1   <= joy_din;
			joy_s2   <= joy_s1;
			if_r     <= if_next;
			// cpu write beats capture in the same cycle
			if (bus.wr && io_sel[SEL_IF])
				if_r <= bus.wdata[4:0];
			if (bus.wr && io_sel[SEL_IE])
				ie_r <= bus.wdata;
		end
	end

	assign irq_rdata = io_sel[SEL_IE] ? ie_r : {3'b111, if_r};  // unused if bits read 1

endmodule

//--- design/gb_sys_top.sv
// system glue top level with decoder, system registers and interrupt controller
`timescale 1ns/1ps

module gb_sys_top (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	input  logic                   ce,
	input  logic                   ce_2x,
	input  logic                   is_gbc,
	input  logic                   gbc_game,
	input  logic                   fast_boot,
	input  gb_bus_pkg::addr_t      cpu_addr,
	input  logic                   cpu_wr,
	input  gb_bus_pkg::byte_t      cpu_wdata,
	output gb_bus_pkg::byte_t      cpu_rdata,
	input  logic                   cpu_stop,
	input  logic                   irq_ack,
	output logic                   irq_n,
	input  gb_bus_pkg::byte_t      mem_rdata,
	input  logic                   ev_vblank,
	input  logic                   ev_lcd,
	input  logic                   ev_timer,
	input  logic                   ev_serial,
	input  gb_irq_pkg::joy_lines_t joy_din,
	output logic [1:0]             joy_p54,
	output logic                   speed,
	output logic                   boot_rom_on,
	output gb_bus_pkg::wram_addr_t wram_addr
);
	import gb_bus_pkg::*;
	import gb_irq_pkg::*;

	io_sel_t  io_sel;     // one hot target select
	byte_t    sys_rdata;
	byte_t    irq_rdata;
	irq_vec_t irq_vec;

	// ------------------------------------------------
	// cpu write side onto the shared bus
	// ------------------------------------------------
	gb_cpu_bus_if bus ();

	assign bus.addr  = cpu_addr;
	assign bus.wdata = cpu_wdata;
	assign bus.wr    = cpu_wr;

	gb_addr_decode u_decode (
		.bus         (bus.sink),
		.is_gbc      (is_gbc),
		.gbc_game    (gbc_game),
		.fast_boot   (fast_boot),
		.boot_rom_on (boot_rom_on),
		.irq_ack     (irq_ack),
		.irq_vec     (irq_vec),
		.sys_rdata   (sys_rdata),
		.irq_rdata   (irq_rdata),
		.mem_rdata   (mem_rdata),
		.io_sel      (io_sel),
		.cpu_rdata   (cpu_rdata)
	);

	gb_sys_regs u_regs (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.bus         (bus.regs),
		.io_sel      (io_sel),
		.is_gbc      (is_gbc),
		.ce          (ce),
		.ce_2x       (ce_2x),
		.cpu_stop    (cpu_stop),
		.joy_din     (joy_din),
		.sys_rdata   (sys_rdata),
		.joy_p54     (joy_p54),
		.speed       (speed),
		.boot_rom_on (boot_rom_on),
		.wram_addr   (wram_addr)
	);

	gb_irq_ctrl u_irq (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.bus         (bus.sink),
		.io_sel      (io_sel),
		.ev_vblank   (ev_vblank),
		.ev_lcd      (ev_lcd),
		.ev_timer    (ev_timer),
		.ev_serial   (ev_serial),
		.irq_ack     (irq_ack),
		.joy_din     (joy_din),
		.irq_rdata   (irq_rdata),
		.irq_vec     (irq_vec),
		.irq_n       (irq_n)
	);

endmodule

//--- dv/gb_sys_properties.sv
// bound checks on the interrupt line, the acknowledge read path and the speed switch
`timescale 1ns/1ps

module gb_sys_properties (
	input logic                   clk_sys,
	input logic                   reset_ss,
	input logic                   irq_n,
	input logic                   irq_ack,
	input logic                   cpu_stop,
	input logic                   speed,
	input gb_bus_pkg::byte_t      cpu_rdata,
	input gb_bus_pkg::byte_t      ie_r,
	input gb_irq_pkg::irq_flags_t if_r
);
	import gb_irq_pkg::*;

	irq_flags_t pending;  // enabled and flagged
	irq_vec_t   exp_vec;  // restart address from the vector table

	assign pending = ie_r[4:0] & if_r;

	// vblank first, joypad last
	always_comb begin
		casez (pending)
			5'b????1: exp_vec = 8'h40;
			5'b???10: exp_vec = 8'h48;
			5'b??100: exp_vec = 8'h50;
			5'b?1000: exp_vec = 8'h58;
			5'b10000: exp_vec = 8'h60;
			default:  exp_vec = 8'h00;  // nothing pending
		endcase
	end

	// ------------------------------------------------
	// interrupt request and vector
	// ------------------------------------------------
	irq_n_matches_pending: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_n == !(|(ie_r[4:0] & if_r)))
		else $error("irq_n does not follow the enabled pending flags");

	ack_reads_vector: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_ack |-> (cpu_rdata == exp_vec))  // vector owns the data bus
		else $error("cpu_rdata is not the vector during acknowledge");

	// speed only flips on a stop
	speed_needs_stop: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!$stable(speed) |-> $past(cpu_stop))
		else $error("speed changed without cpu_stop");

endmodule

bind gb_sys_top gb_sys_properties u_props (
	.clk_sys   (clk_sys),
	.reset_ss  (reset_ss),
	.irq_n     (irq_n),
	.irq_ack   (irq_ack),
	.cpu_stop  (cpu_stop),
	.speed     (speed),
	.cpu_rdata (cpu_rdata),
	.ie_r      (u_irq.ie_r),
	.if_r      (u_irq.if_r)
);

//--- dv/gb_sys_tb.sv
// directed testbench for the system glue top level
`timescale 1ns/1ps

module gb_sys_tb;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS  = 6;
	localparam int TEST_CYCLES = 200;  // generous budget per test

	logic        clk_sys;
	logic        reset_ss;
	logic        ce;
	logic        ce_2x;
	logic        is_gbc;
	logic        gbc_game;
	logic        fast_boot;
	logic [15:0] cpu_addr;
	logic        cpu_wr;
	logic [7:0]  cpu_wdata;
	logic [7:0]  cpu_rdata;
	logic        cpu_stop;
	logic        irq_ack;
	logic        irq_n;
	logic [7:0]  mem_rdata;
	logic        ev_vblank;
	logic        ev_lcd;
	logic        ev_timer;
	logic        ev_serial;
	logic [3:0]  joy_din;
	logic [1:0]  joy_p54;
	logic        speed;
	logic        boot_rom_on;
	logic [14:0] wram_addr;

	int          errors;
	int          tests_run;
	logic [31:0] lcg_state = 32'h4663;

	gb_sys_top DUT (.*);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------
	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];  // middle bits mix best
	endfunction

	task automatic step();
		@(posedge clk_sys);
		#2;  // drive slot
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_wr    = 1'b1;
		step();
		cpu_wr    = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		cpu_addr = addr;
		#1;  // combinational read path settles
		data = cpu_rdata;
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input string name);
		logic [7:0] rd;
		cpu_read(addr, rd);
		check(name, {8'h00, rd}, {8'h00, exp});
	endtask

	// ------------------------------------------------
	// directed tests
	// ------------------------------------------------
	task automatic test_reset_values();
		tests_run++;
		read_check(16'hFFFF, 8'h00, "ie");
		read_check(16'hFF0F, 8'hE0, "if");     // three unused bits high
		read_check(16'hFF70, 8'hF9, "svbk");   // bank 1
		read_check(16'hFF4D, 8'h7E, "key1");
		read_check(16'hFF00, 8'hCF, "p1");     // 11, p54 00, lines idle
		check("joy_p54", {14'd0, joy_p54}, 16'h0000);
		check("boot_rom_on", {15'd0, boot_rom_on}, 16'h0001);
		check("speed", {15'd0, speed}, 16'h0000);
		check("irq_n", {15'd0, irq_n}, 16'h0001);
	endtask

	task automatic test_reg_writes();
		logic [7:0] d;
		tests_run++;
		cpu_write(16'hFF00, 8'h20);            // select pair 10
		check("joy_p54", {14'd0, joy_p54}, 16'h0002);
		read_check(16'hFF00, 8'hEF, "p1");
		d = lcg_next();
		cpu_write(16'hFF72, d);
		read_check(16'hFF72, d, "ff72");
		d = lcg_next();
		cpu_write(16'hFF73, d);
		read_check(16'hFF73, d, "ff73");
		d = lcg_next();
		cpu_write(16'hFF74, d);
		read_check(16'hFF74, d, "ff74");
		d = lcg_next();
		cpu_write(16'hFFFF, d);
		read_check(16'hFFFF, d, "ie");
		d = lcg_next();
		cpu_write(16'hFF75, d);
		read_check(16'hFF75, {1'b1, d[6:4], 4'hF}, "ff75");  // only 6..4 kept
		cpu_write(16'hFF70, 8'h00);
		read_check(16'hFF70, 8'hF9, "svbk");   // zero becomes bank 1
		gbc_game = 1'b0;
		read_check(16'hFF74, 8'hFF, "ff74");   // hidden from dmg games
		gbc_game = 1'b1;
		read_check(16'hFF03, 8'hFF, "open_bus");
		mem_rdata = lcg_next();
		read_check(16'hC000, mem_rdata, "mem_rdata");
	endtask

	task automatic test_irq_priority();
		tests_run++;
		cpu_write(16'hFFFF, 8'h1F);
		cpu_write(16'hFF0F, 8'h00);
		ev_timer  = 1'b1;  // one cycle pulses
		ev_serial = 1'b1;
		step();
		ev_timer  = 1'b0;
		ev_serial = 1'b0;
		read_check(16'hFF0F, 8'hEC, "if");
		check("irq_n", {15'd0, irq_n}, 16'h0000);
		irq_ack = 1'b1;
		read_check(16'hFF0F, 8'h50, "vector");  // timer beats serial
		step();
		irq_ack = 1'b0;
		step();                                  // falling ack clears timer
		read_check(16'hFF0F, 8'hE8, "if");
		irq_ack = 1'b1;
		read_check(16'hFF0F, 8'h58, "vector");
		step();
		irq_ack = 1'b0;
		step();
		read_check(16'hFF0F, 8'hE0, "if");
		check("irq_n", {15'd0, irq_n}, 16'h0001);
	endtask

	task automatic test_joypad();
		logic [7:0] rd;
		logic       seen;
		tests_run++;
		seen = 1'b0;
		joy_din = 4'b1011;  // p12 pressed
		for (int i = 0; i < 3 && !seen; i++) begin
			step();
			cpu_read(16'hFF0F, rd);
			seen = rd[4];
		end
		if (!seen) begin
			errors++;
			$display("joypad flag was not set within three cycles of the falling line");
		end
		read_check(16'hFF0F, 8'hF0, "if");
		cpu_write(16'hFF0F, 8'h00);
		read_check(16'hFF0F, 8'hE0, "if");
		check("irq_n", {15'd0, irq_n}, 16'h0001);
		joy_din = 4'hF;     // release, no flag on rise
	endtask

	task automatic test_speed_banking();
		tests_run++;
		cpu_write(16'hFF4D, 8'h01);
		read_check(16'hFF4D, 8'h7F, "key1");   // armed
		cpu_stop = 1'b1;
		step();
		cpu_stop = 1'b0;
		check("speed", {15'd0, speed}, 16'h0001);
		read_check(16'hFF4D, 8'hFE, "key1");
		cpu_write(16'hFF70, 8'h05);
		cpu_addr = 16'hD123;
		#1;
		check("wram_addr", {1'b0, wram_addr}, 16'h5123);
		cpu_addr = 16'hC123;                   // lower half is bank 0
		#1;
		check("wram_addr", {1'b0, wram_addr}, 16'h0123);
	endtask

	task automatic test_boot_rom();
		tests_run++;
		fast_boot = 1'b1;
		read_check(16'hFF50, 8'h42, "ff50");
		cpu_write(16'hFF50, 8'h01);            // not the cgb unmap value
		check("boot_rom_on", {15'd0, boot_rom_on}, 16'h0001);
		cpu_write(16'hFF50, 8'h11);
		check("boot_rom_on", {15'd0, boot_rom_on}, 16'h0000);
		read_check(16'hFF50, 8'hFF, "ff50");
		fast_boot = 1'b0;
	endtask

	// ------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------
	initial begin
		errors    = 0;
		tests_run = 0;
		reset_ss  = 1'b1;
		ce        = 1'b1;
		ce_2x     = 1'b1;
		is_gbc    = 1'b1;
		gbc_game  = 1'b1;
		fast_boot = 1'b0;
		cpu_addr  = 16'h0000;
		cpu_wr    = 1'b0;
		cpu_wdata = 8'h00;
		cpu_stop  = 1'b0;
		irq_ack   = 1'b0;
		mem_rdata = 8'h00;
		ev_vblank = 1'b0;
		ev_lcd    = 1'b0;
		ev_timer  = 1'b0;
		ev_serial = 1'b0;
		joy_din   = 4'hF;
		repeat (2) @(posedge clk_sys);
		#2;
		reset_ss = 1'b0;
		test_reset_values();
		test_reg_writes();
		test_irq_priority();
		test_joypad();
		test_speed_banking();
		test_boot_rom();
		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- all.f
+incdir+design
design/gb_bus_pkg.sv
design/gb_irq_pkg.sv
design/gb_cpu_bus_if.sv
design/gb_addr_decode.sv
design/gb_sys_regs.sv
design/gb_irq_ctrl.sv
design/gb_sys_top.sv
dv/gb_sys_properties.sv
dv/gb_sys_tb.sv

//--- run.sh
#!/bin/sh
# build the system glue testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f all.f --top-module gb_sys_tb -o gb_sys_sim \
	> build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/gb_sys_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log

grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
